// ==== tcp_server.f ====
+incdir+design
design/tcp_seg_pkg.sv
design/tcp_conn_pkg.sv
design/tcp_bank_slot.sv
design/tcp_bank_arbiter.sv
design/tcp_conn_fsm.sv
design/tcp_seg_builder.sv
design/tcp_tx_sched.sv
design/tcp_server_top.sv
testbench/tcp_server_props.sv
testbench/tcp_server_tb.sv

// ==== Makefile ====
SIM       := verilator
SIM_FLAGS := --binary --timing --assert -j 0
TOP       := tcp_server_tb
FLIST     := tcp_server.f

OBJ_DIR   := obj_dir
SIM_BIN   := $(OBJ_DIR)/V$(TOP)
LOG       := sim.log
SRCS      := $(shell grep -v '^+' $(FLIST))
HDRS      := design/tcp_defines.svh

.PHONY: all run clean

all: run

$(SIM_BIN): $(SRCS) $(HDRS) $(FLIST)
	$(SIM) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

run: $(SIM_BIN)
	./$(SIM_BIN) 2>&1 | tee $(LOG)
	@if grep -q "Simulation FAILED" $(LOG); then exit 1; fi
	@grep -q "Simulation PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== testbench/tcp_server_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "tcp_defines.svh"

// Free-running testbench clock
module tb_clkgen
#(
	parameter int PERIOD_NS = 10
)
(
	output logic clk_o
);
	initial
	begin
		clk_o = 1'b0;
		forever
			#(PERIOD_NS / 2) clk_o = ~clk_o;
	end
endmodule

module tcp_server_tb;
	import tcp_seg_pkg::*;

	localparam int NB = `TCP_MEM_NUM;
	localparam int WAIT_LIMIT = 200;
	localparam int BUSY_CYCLES = 6;
	localparam port_t PEER_PORT = 16'hC35A;
	localparam seq_t PEER_ISN = 32'h1000_0000;
	localparam len_t RX_LEN = 16'd100;
	localparam len_t TX_LEN = 16'd1450;
	// ISS zero, plus one for the SYN, plus two full data segments
	localparam seq_t TX_END = 32'd1 + 32'd2 * `TCP_SEG_BYTES;

	typedef logic [NB-1:0] bank_vec_t;

	// Received segment and the control reply it should produce
	typedef struct packed {
		flags_t flags;
		port_t port;
		seq_t seq;
		seq_t ack;
		len_t len;
		logic exp_ctrl;
		logic [3:0] exp_delay;
		flags_t exp_flags;
		seq_t exp_seq;
		logic chk_peer;
		seq_t exp_ack;
		logic exp_listen;
		logic exp_estblsh;
		logic run_data;
	} seg_case_t;

	logic clk;
	logic rst_n;
	logic rcv;
	port_t src_port;
	flags_t rx_flags;
	seq_t rx_seq;
	seq_t rx_ack;
	len_t rx_len;
	len_t rx_win;
	len_t ram_len;
	logic wdat_stop;
	logic busy;
	bank_vec_t wr_lock;
	bank_vec_t rd_lock;
	logic rcv_rd;
	port_t dest_port;
	flags_t tx_flags;
	seq_t tx_seq;
	seq_t tx_ack;
	len_t tx_len;
	logic ctrl_start;
	logic wdat_start;
	logic st_listen;
	logic st_estblsh;
	bank_vec_t data_sel;

	seg_case_t cases[$];
	string case_names[$];
	int checks;
	int errors;
	bit timed_out;

	tb_clkgen #(
		.PERIOD_NS(10)
	) i_clkgen
	(
		.clk_o(clk)
	);

	// Replies leave from `TCP_LOCAL_PORT, which no DUT port carries
	tcp_server_top i_dut
	(
		.clk(clk),
		.rst_n(rst_n),
		.tcp_op_rcv_i(rcv),
		.tcp_op_rcv_rd_o(rcv_rd),
		.tcp_source_port_i(src_port),
		.tcp_flags_i(rx_flags),
		.tcp_seq_num_i(rx_seq),
		.tcp_ack_num_i(rx_ack),
		.tcp_data_len_i(rx_len),
		.tcp_window_i(rx_win),
		.ram_dat_len_i(ram_len),
		.tcp_wdat_stop_i(wdat_stop),
		.trnsmt_busy_i(busy),
		.mem_wr_lock_flg_i(wr_lock),
		.mem_rd_lock_flg_i(rd_lock),
		.tcp_dest_port_o(dest_port),
		.tcp_flags_o(tx_flags),
		.tcp_seq_num_o(tx_seq),
		.tcp_ack_num_o(tx_ack),
		.tcp_data_len_o(tx_len),
		.ctrl_cmd_start_o(ctrl_start),
		.tcp_wdat_start_o(wdat_start),
		.tcp_state_listen_o(st_listen),
		.tcp_state_estblsh_o(st_estblsh),
		.mem_data_sel_o(data_sel)
	);

	// --------------------------------------------------
	// Checking and reporting
	// --------------------------------------------------
	task automatic check_val(
		input string name,
		input logic [31:0] got,
		input logic [31:0] exp
	);
		checks++;
		assert (got === exp)
		else
		begin
			$display("Mismatch %s: got %h, expected %h", name, got, exp);
			errors++;
		end
	endtask

	task automatic check_true(input bit cond, input string what);
		checks++;
		assert (cond)
		else
		begin
			$display("%s", what);
			errors++;
		end
	endtask

	task automatic report_timeout(input string what);
		$display("Timeout waiting for %s", what);
		errors++;
		timed_out = 1'b1;
	endtask

	task automatic report_test(input string name, input int err0);
		if (errors == err0)
			$display("Test %s: ok", name);
		else
			$display("Test %s: %0d errors", name, errors - err0);
	endtask

	task automatic add_case(
		input string name,
		input flags_t flags,
		input port_t port,
		input seq_t seq,
		input seq_t ack,
		input len_t len,
		input logic exp_ctrl,
		input logic [3:0] exp_delay,
		input flags_t exp_flags,
		input seq_t exp_seq,
		input logic chk_peer,
		input seq_t exp_ack,
		input logic exp_listen,
		input logic exp_estblsh,
		input logic run_data
	);
		seg_case_t c;
		c.flags = flags;
		c.port = port;
		c.seq = seq;
		c.ack = ack;
		c.len = len;
		c.exp_ctrl = exp_ctrl;
		c.exp_delay = exp_delay;
		c.exp_flags = exp_flags;
		c.exp_seq = exp_seq;
		c.chk_peer = chk_peer;
		c.exp_ack = exp_ack;
		c.exp_listen = exp_listen;
		c.exp_estblsh = exp_estblsh;
		c.run_data = run_data;
		cases.push_back(c);
		case_names.push_back(name);
	endtask

	// Peer segments in connection order
	// Data sends run after the handshake
	task automatic fill_table();
		add_case("ACK in LISTEN", 6'h10, 16'h4E21, 32'h0000_5555, 32'h0000_7777, 16'd0,
			1'b1, 4'd1, 6'h14, 32'h0000_7777, 1'b0, 32'd0, 1'b1, 1'b0, 1'b0);
		add_case("passive open SYN", 6'h02, PEER_PORT, PEER_ISN, 32'd0, 16'd0,
			1'b1, 4'd1, 6'h12, 32'd0, 1'b1, PEER_ISN + 32'd1, 1'b0, 1'b0, 1'b0);
		add_case("handshake ACK", 6'h10, PEER_PORT, PEER_ISN + 32'd1, 32'd1, 16'd0,
			1'b0, 4'd0, 6'h00, 32'd0, 1'b0, 32'd0, 1'b0, 1'b1, 1'b1);
		add_case("received data", 6'h18, PEER_PORT, PEER_ISN + 32'd1, TX_END, RX_LEN,
			1'b1, 4'd1, 6'h10, TX_END, 1'b1, PEER_ISN + 32'd1 + 32'(RX_LEN),
			1'b0, 1'b1, 1'b0);
		add_case("FIN", 6'h11, PEER_PORT, PEER_ISN + 32'd1 + 32'(RX_LEN), TX_END, 16'd0,
			1'b1, 4'd2, 6'h11, TX_END + 32'd1, 1'b1, PEER_ISN + 32'd2 + 32'(RX_LEN),
			1'b0, 1'b0, 1'b0);
		add_case("closing ACK", 6'h10, PEER_PORT, PEER_ISN + 32'd2 + 32'(RX_LEN),
			TX_END + 32'd1, 16'd0, 1'b0, 4'd0, 6'h00, 32'd0, 1'b0, 32'd0,
			1'b1, 1'b0, 1'b0);
	endtask

	// --------------------------------------------------
	// Bounded waits
	// --------------------------------------------------
	task automatic present_segment(input seg_case_t c);
		int n;
		bit taken;
		n = 0;
		taken = 1'b0;
		rcv <= 1'b1;
		src_port <= c.port;
		rx_flags <= c.flags;
		rx_seq <= c.seq;
		rx_ack <= c.ack;
		rx_len <= c.len;
		while (!taken && (n < WAIT_LIMIT))
		begin
			@(posedge clk);
			n++;
			taken = rcv_rd;
		end
		// Consume cycle has just ended
		rcv <= 1'b0;
		if (!taken)
			report_timeout("the segment read strobe");
	endtask

	task automatic wait_ctrl(output int delay);
		int n;
		n = 0;
		delay = -1;
		while ((delay < 0) && (n < WAIT_LIMIT))
		begin
			@(posedge clk);
			n++;
			if (ctrl_start)
				delay = n;
		end
		if (delay < 0)
			report_timeout("a control segment");
	endtask

	task automatic wait_data_start(output bit seen);
		int n;
		n = 0;
		seen = 1'b0;
		while (!seen && (n < WAIT_LIMIT))
		begin
			@(posedge clk);
			n++;
			seen = wdat_start;
		end
		if (!seen)
			report_timeout("a data segment start");
	endtask

	task automatic wait_state(input logic listen, input logic estblsh);
		int n;
		n = 0;
		while (((st_listen !== listen) || (st_estblsh !== estblsh)) && (n < WAIT_LIMIT))
		begin
			@(posedge clk);
			n++;
		end
		if ((st_listen !== listen) || (st_estblsh !== estblsh))
			report_timeout("the expected connection state");
	endtask

	// --------------------------------------------------
	// Test steps
	// --------------------------------------------------
	task automatic run_case(input int idx);
		seg_case_t c;
		int delay;
		int err0;
		c = cases[idx];
		err0 = errors;
		present_segment(c);
		if (!timed_out && c.exp_ctrl)
		begin
			wait_ctrl(delay);
			if (delay >= 0)
			begin
				check_true(delay == int'(c.exp_delay),
					$sformatf("Control segment came %0d cycles after the read, expected %0d",
					delay, c.exp_delay));
				check_val("tcp_flags_o", 32'(tx_flags), 32'(c.exp_flags));
				check_val("tcp_seq_num_o", tx_seq, c.exp_seq);
				check_val("tcp_data_len_o", 32'(tx_len), 32'd0);
				if (c.chk_peer)
				begin
					check_val("tcp_ack_num_o", tx_ack, c.exp_ack);
					check_val("tcp_dest_port_o", 32'(dest_port), 32'(PEER_PORT));
				end
			end
		end
		if (!timed_out)
			wait_state(c.exp_listen, c.exp_estblsh);
		report_test(case_names[idx], err0);
	endtask

	task automatic hold_busy();
		repeat (BUSY_CYCLES)
		begin
			@(posedge clk);
			check_true(!wdat_start, "Data segment started while the transmitter was busy");
			check_val("mem_data_sel_o", 32'(data_sel), 32'd0);
		end
		busy <= 1'b0;
	endtask

	// Banks 2 and 5 filled and served in round-robin order
	task automatic run_data_phase();
		int banks[2];
		seq_t exp_seq;
		int err0;
		bit seen;
		banks[0] = 2;
		banks[1] = 5;
		err0 = errors;
		exp_seq = 32'd1;
		wr_lock <= (bank_vec_t'(1) << banks[0]) | (bank_vec_t'(1) << banks[1]);
		ram_len <= TX_LEN;
		for (int i = 0; i < 2; i++)
		begin
			if (!timed_out)
			begin
				wait_data_start(seen);
				if (seen)
				begin
					check_val("mem_data_sel_o", 32'(data_sel), 32'd1 << banks[i]);
					check_val("tcp_seq_num_o", tx_seq, exp_seq);
					check_val("tcp_flags_o", 32'(tx_flags), 32'h18);
					check_val("tcp_data_len_o", 32'(tx_len), 32'(TX_LEN));
					// Encoder streams the payload for a few cycles
					repeat (3) @(posedge clk);
					wdat_stop <= 1'b1;
					@(posedge clk);
					wdat_stop <= 1'b0;
					wr_lock <= wr_lock & ~(bank_vec_t'(1) << banks[i]);
					busy <= (i == 0);
					exp_seq = exp_seq + `TCP_SEG_BYTES;
					@(posedge clk);
					check_val("tcp_seq_num_o", tx_seq, exp_seq);
					if (i == 0)
						hold_busy();
				end
			end
		end
		report_test("data sends", err0);
	endtask

	initial
	begin
		int err0;
		rst_n = 1'b0;
		rcv = 1'b0;
		src_port = '0;
		rx_flags = '0;
		rx_seq = '0;
		rx_ack = '0;
		rx_len = '0;
		rx_win = 16'hFFFF;
		ram_len = '0;
		wdat_stop = 1'b0;
		busy = 1'b0;
		wr_lock = '0;
		rd_lock = '0;
		checks = 0;
		errors = 0;
		timed_out = 1'b0;
		fill_table();

		repeat (5) @(posedge clk);
		rst_n <= 1'b1;
		@(posedge clk);
		err0 = errors;
		check_val("tcp_op_rcv_rd_o", 32'(rcv_rd), 32'd0);
		check_val("ctrl_cmd_start_o", 32'(ctrl_start), 32'd0);
		check_val("tcp_wdat_start_o", 32'(wdat_start), 32'd0);
		check_val("tcp_state_listen_o", 32'(st_listen), 32'd1);
		check_val("tcp_state_estblsh_o", 32'(st_estblsh), 32'd0);
		check_val("mem_data_sel_o", 32'(data_sel), 32'd0);
		report_test("reset", err0);

		foreach (cases[i])
		begin
			if (!timed_out)
			begin
				run_case(i);
				if (!timed_out && cases[i].run_data)
					run_data_phase();
			end
		end

		$display("Checks run: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("Simulation PASSED");
		else
			$display("Simulation FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// ==== testbench/tcp_server_props.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "tcp_defines.svh"

module tcp_server_props
(
	input wire clk,
	input wire rst_n,
	input wire rd_i,
	input wire ctrl_start_i,
	input wire wdat_start_i,
	input wire estblsh_i,
	input wire [`TCP_MEM_NUM-1:0] sel_i
);
	// --------------------------------------------------
	// Strobes last one cycle
	// --------------------------------------------------
	a_rd_pulse: assert property (@(posedge clk) disable iff (!rst_n) rd_i |=> !rd_i)
		else $error("read strobe high for more than one cycle");

	a_ctrl_pulse: assert property (@(posedge clk) disable iff (!rst_n)
		ctrl_start_i |=> !ctrl_start_i)
		else $error("control start high for more than one cycle");

	a_wdat_pulse: assert property (@(posedge clk) disable iff (!rst_n)
		wdat_start_i |=> !wdat_start_i)
		else $error("data start high for more than one cycle");

	// At most one bank granted
	a_sel_onehot: assert property (@(posedge clk) disable iff (!rst_n) $onehot0(sel_i))
		else $error("bank selection is not one-hot");

	a_start_est: assert property (@(posedge clk) disable iff (!rst_n)
		wdat_start_i |-> estblsh_i)
		else $error("data start outside ESTABLISHED");

endmodule

bind tcp_server_top tcp_server_props i_props
(
	.clk(clk),
	.rst_n(rst_n),
	.rd_i(tcp_op_rcv_rd_o),
	.ctrl_start_i(ctrl_cmd_start_o),
	.wdat_start_i(tcp_wdat_start_o),
	.estblsh_i(tcp_state_estblsh_o),
	.sel_i(mem_data_sel_o)
);

`default_nettype wire

// ==== design/tcp_server_top.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "tcp_defines.svh"

module tcp_server_top
(
	input wire clk,
	input wire rst_n,
	input wire tcp_op_rcv_i,
	output logic tcp_op_rcv_rd_o,
	input wire tcp_seg_pkg::port_t tcp_source_port_i,
	input wire tcp_seg_pkg::flags_t tcp_flags_i,
	input wire tcp_seg_pkg::seq_t tcp_seq_num_i,
	input wire tcp_seg_pkg::seq_t tcp_ack_num_i,
	input wire tcp_seg_pkg::len_t tcp_data_len_i,
	input wire tcp_seg_pkg::len_t tcp_window_i,
	input wire tcp_seg_pkg::len_t ram_dat_len_i,
	input wire tcp_wdat_stop_i,
	input wire trnsmt_busy_i,
	input wire [`TCP_MEM_NUM-1:0] mem_wr_lock_flg_i,
	input wire [`TCP_MEM_NUM-1:0] mem_rd_lock_flg_i,
	output tcp_seg_pkg::port_t tcp_dest_port_o,
	output tcp_seg_pkg::flags_t tcp_flags_o,
	output tcp_seg_pkg::seq_t tcp_seq_num_o,
	output tcp_seg_pkg::seq_t tcp_ack_num_o,
	output tcp_seg_pkg::len_t tcp_data_len_o,
	output logic ctrl_cmd_start_o,
	output logic tcp_wdat_start_o,
	output logic tcp_state_listen_o,
	output logic tcp_state_estblsh_o,
	output logic [`TCP_MEM_NUM-1:0] mem_data_sel_o
);
	import tcp_conn_pkg::*;

	seg_event_t seg_event;
	conn_state_t state;
	logic seg_done;
	logic sel_rdy;
	logic [`TCP_MEM_NUM-1:0] bank_req;

	// --------------------------------------------------
	// Connection control
	// --------------------------------------------------
	tcp_conn_fsm i_conn_fsm
	(
		.clk(clk),
		.rst_n(rst_n),
		.tcp_op_rcv_i(tcp_op_rcv_i),
		.tcp_flags_i(tcp_flags_i),
		.tcp_source_port_i(tcp_source_port_i),
		.trnsmt_busy_i(trnsmt_busy_i),
		.ctrl_start_i(ctrl_cmd_start_o),
		.wdat_start_i(tcp_wdat_start_o),
		.tcp_op_rcv_rd_o(tcp_op_rcv_rd_o),
		.seg_event_o(seg_event),
		.state_o(state),
		.peer_port_o(tcp_dest_port_o)
	);

	tcp_seg_builder i_seg_builder
	(
		.clk(clk),
		.rst_n(rst_n),
		.seg_event_i(seg_event),
		.state_i(state),
		.tcp_seq_num_i(tcp_seq_num_i),
		.tcp_ack_num_i(tcp_ack_num_i),
		.tcp_data_len_i(tcp_data_len_i),
		.ram_dat_len_i(ram_dat_len_i),
		.wdat_start_i(tcp_wdat_start_o),
		.seg_done_i(seg_done),
		.tcp_flags_o(tcp_flags_o),
		.tcp_seq_num_o(tcp_seq_num_o),
		.tcp_ack_num_o(tcp_ack_num_o),
		.tcp_data_len_o(tcp_data_len_o),
		.ctrl_cmd_start_o(ctrl_cmd_start_o)
	);

	tcp_tx_sched i_tx_sched
	(
		.clk(clk),
		.rst_n(rst_n),
		.state_i(state),
		.seg_event_i(seg_event),
		.tcp_op_rcv_i(tcp_op_rcv_i),
		.trnsmt_busy_i(trnsmt_busy_i),
		.ctrl_start_i(ctrl_cmd_start_o),
		.tcp_ack_num_i(tcp_ack_num_i),
		.tcp_window_i(tcp_window_i),
		.seq_i(tcp_seq_num_o),
		.sel_rdy_i(sel_rdy),
		.tcp_wdat_stop_i(tcp_wdat_stop_i),
		.wdat_start_o(tcp_wdat_start_o),
		.seg_done_o(seg_done)
	);

	// --------------------------------------------------
	// Bank selection
	// --------------------------------------------------
	for (genvar b = 0; b < `TCP_MEM_NUM; b++)
	begin : g_slot
		tcp_bank_slot i_bank_slot
		(
			.clk(clk),
			.rst_n(rst_n),
			.wr_lock_i(mem_wr_lock_flg_i[b]),
			.rd_lock_i(mem_rd_lock_flg_i[b]),
			.selected_i(mem_data_sel_o[b]),
			.wdat_start_i(tcp_wdat_start_o),
			.req_o(bank_req[b])
		);
	end

	tcp_bank_arbiter #(
		.N_BANKS(`TCP_MEM_NUM)
	) i_bank_arbiter
	(
		.clk(clk),
		.rst_n(rst_n),
		.req_i(bank_req),
		.block_i(trnsmt_busy_i),
		.stop_i(seg_done),
		.sel_o(mem_data_sel_o),
		.sel_rdy_o(sel_rdy)
	);

	assign tcp_state_listen_o = (state == ST_LISTEN);
	assign tcp_state_estblsh_o = (state == ST_ESTABLISHED);

endmodule

`default_nettype wire

// ==== design/tcp_tx_sched.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "tcp_defines.svh"

module tcp_tx_sched
(
	input wire clk,
	input wire rst_n,
	input wire tcp_conn_pkg::conn_state_t state_i,
	input wire tcp_conn_pkg::seg_event_t seg_event_i,
	input wire tcp_op_rcv_i,
	input wire trnsmt_busy_i,
	input wire ctrl_start_i,
	input wire tcp_seg_pkg::seq_t tcp_ack_num_i,
	input wire tcp_seg_pkg::len_t tcp_window_i,
	input wire tcp_seg_pkg::seq_t seq_i,
	input wire sel_rdy_i,
	input wire tcp_wdat_stop_i,
	output logic wdat_start_o,
	output logic seg_done_o
);
	import tcp_seg_pkg::*;
	import tcp_conn_pkg::*;

	localparam int CNT_W = $clog2(`TCP_MAX_INFLIGHT + 1);

	logic start_q;
	logic lock_q;
	logic send_ok;
	logic [CNT_W-1:0] cnt_q;
	seq_t win_q;

	// Idle means no waiting segment, no control send and no data in flight
	assign send_ok = (state_i == ST_ESTABLISHED) & ~tcp_op_rcv_i & ~ctrl_start_i &
		~lock_q & ~trnsmt_busy_i & (cnt_q < CNT_W'(`TCP_MAX_INFLIGHT)) &
		(win_q > seq_t'(`TCP_WIN_MIN)) & sel_rdy_i;

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			start_q <= 1'b0;
		else
			start_q <= ~start_q & send_ok;
	end

	// Held from data start to encoder stop
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			lock_q <= 1'b0;
		else if ((state_i == ST_CLOSED) | tcp_wdat_stop_i)
			lock_q <= 1'b0;
		else if (start_q)
			lock_q <= 1'b1;
	end

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			cnt_q <= '0;
		else if ((state_i != ST_ESTABLISHED) | seg_event_i.ack)
			cnt_q <= '0;
		else if (start_q)
			cnt_q <= cnt_q + 1'b1;
	end

	// Usable peer window
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			win_q <= '0;
		else if (seg_event_i.consume & (state_i == ST_SYN_RCVD))
			win_q <= seq_t'(tcp_window_i);
		else if (seg_event_i.consume & (state_i == ST_ESTABLISHED))
			win_q <= tcp_ack_num_i + seq_t'(tcp_window_i) - seq_i;
	end

	assign wdat_start_o = start_q;
	assign seg_done_o = tcp_wdat_stop_i & lock_q;

endmodule

`default_nettype wire

// ==== design/tcp_seg_builder.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "tcp_defines.svh"

module tcp_seg_builder
(
	input wire clk,
	input wire rst_n,
	input wire tcp_conn_pkg::seg_event_t seg_event_i,
	input wire tcp_conn_pkg::conn_state_t state_i,
	input wire tcp_seg_pkg::seq_t tcp_seq_num_i,
	input wire tcp_seg_pkg::seq_t tcp_ack_num_i,
	input wire tcp_seg_pkg::len_t tcp_data_len_i,
	input wire tcp_seg_pkg::len_t ram_dat_len_i,
	input wire wdat_start_i,
	input wire seg_done_i,
	output tcp_seg_pkg::flags_t tcp_flags_o,
	output tcp_seg_pkg::seq_t tcp_seq_num_o,
	output tcp_seg_pkg::seq_t tcp_ack_num_o,
	output tcp_seg_pkg::len_t tcp_data_len_o,
	output logic ctrl_cmd_start_o
);
	import tcp_seg_pkg::*;
	import tcp_conn_pkg::*;

	resp_kind_t resp;
	logic ctrl_q;
	logic est_open;
	logic in_order;
	logic fin_est;
	seq_t seg_end;
	seq_t seq_q;
	seq_t ack_q;
	seq_t rcv_nxt_q;
	flags_t flags_q;
	len_t len_q;

	assign seg_end = tcp_seq_num_i + seq_t'(tcp_data_len_i);
	assign in_order = (tcp_seq_num_i == rcv_nxt_q);
	assign est_open = seg_event_i.ack & ~seg_event_i.syn & ~seg_event_i.rst &
		(state_i == ST_SYN_RCVD);
	assign fin_est = seg_event_i.fin & ~seg_event_i.rst & (state_i == ST_ESTABLISHED);

	// --------------------------------------------------
	// Response selection
	// --------------------------------------------------
	always_comb
	begin
		resp = RESP_NONE;
		case (state_i)
			ST_LISTEN:
				if (seg_event_i.syn & ~seg_event_i.ack & ~seg_event_i.rst)
					resp = RESP_SYNACK;
				else if (seg_event_i.ack & ~seg_event_i.rst)
					resp = RESP_RSTACK;
			// Out of order data still gets an ACK carrying the old number
			ST_ESTABLISHED:
				if (seg_event_i.ack & ~seg_event_i.fin & ~seg_event_i.rst &
					(tcp_data_len_i != '0))
					resp = RESP_ACK;
			ST_CLOSE_WAIT:
				resp = RESP_FINACK;
			ST_CLOSED:
				if (seg_event_i.consume & ~seg_event_i.rst)
					resp = seg_event_i.ack ? RESP_RSTACK : RESP_RST;
			default:
				resp = RESP_NONE;
		endcase
	end

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			ctrl_q <= 1'b0;
		else
			ctrl_q <= (resp != RESP_NONE);
	end

	// --------------------------------------------------
	// Outgoing header fields
	// --------------------------------------------------
	always_ff @(posedge clk)
	begin
		if (wdat_start_i)
			flags_q <= FLAGS_PSHACK;
		else
		begin
			case (resp)
				RESP_SYNACK: flags_q <= FLAGS_SYNACK;
				RESP_ACK: flags_q <= FLAGS_ACK;
				RESP_FINACK: flags_q <= FLAGS_FINACK;
				RESP_RST: flags_q <= FLAGS_RST;
				RESP_RSTACK: flags_q <= FLAGS_RSTACK;
				default: flags_q <= flags_q;
			endcase
		end
	end

	// Control segments carry no payload
	always_ff @(posedge clk)
	begin
		if (wdat_start_i)
			len_q <= ram_dat_len_i;
		else if (resp != RESP_NONE)
			len_q <= '0;
	end

	// Send sequence starting from a zero ISS
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			seq_q <= '0;
		else if (resp == RESP_SYNACK)
			seq_q <= '0;
		else if (resp == RESP_RSTACK)
			seq_q <= tcp_ack_num_i;
		else if (est_open | (resp == RESP_FINACK))
			seq_q <= seq_q + 32'd1;
		else if (seg_done_i)
			seq_q <= seq_q + seq_t'(`TCP_SEG_BYTES);
	end

	always_ff @(posedge clk)
	begin
		if (resp == RESP_SYNACK)
			ack_q <= tcp_seq_num_i + 32'd1;
		else if (resp == RESP_RSTACK)
			ack_q <= tcp_seq_num_i;
		else if (resp == RESP_RST)
			ack_q <= seg_end;
		else if (fin_est)
			ack_q <= tcp_seq_num_i + 32'd1;
		else if ((resp == RESP_ACK) & in_order)
			ack_q <= seg_end;
	end

	// Next in-order byte expected from the peer
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			rcv_nxt_q <= '0;
		else if (est_open)
			rcv_nxt_q <= seg_end;
		else if ((resp == RESP_ACK) & in_order)
			rcv_nxt_q <= seg_end;
	end

	// Data fields appear together with the start pulse
	assign tcp_flags_o = wdat_start_i ? FLAGS_PSHACK : flags_q;
	assign tcp_seq_num_o = seq_q;
	assign tcp_ack_num_o = ack_q;
	assign tcp_data_len_o = wdat_start_i ? ram_dat_len_i : len_q;
	assign ctrl_cmd_start_o = ctrl_q;

endmodule

`default_nettype wire

// ==== design/tcp_conn_fsm.sv ====
`timescale 1ns/1ps
`default_nettype none

module tcp_conn_fsm
(
	input wire clk,
	input wire rst_n,
	input wire tcp_op_rcv_i,
	input wire tcp_seg_pkg::flags_t tcp_flags_i,
	input wire tcp_seg_pkg::port_t tcp_source_port_i,
	input wire trnsmt_busy_i,
	input wire ctrl_start_i,
	input wire wdat_start_i,
	output logic tcp_op_rcv_rd_o,
	output tcp_conn_pkg::seg_event_t seg_event_o,
	output tcp_conn_pkg::conn_state_t state_o,
	output tcp_seg_pkg::port_t peer_port_o
);
	import tcp_seg_pkg::*;
	import tcp_conn_pkg::*;

	conn_state_t state_q;
	seg_event_t ev;
	logic rd_q;
	logic open_req;
	port_t peer_port_q;

	// --------------------------------------------------
	// Segment intake
	// --------------------------------------------------
	// One read strobe per waiting segment, never back to back
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			rd_q <= 1'b0;
		else
			rd_q <= tcp_op_rcv_i & ~rd_q & ~ctrl_start_i & ~wdat_start_i & ~trnsmt_busy_i;
	end

	always_comb
	begin
		ev.consume = rd_q & tcp_op_rcv_i;
		ev.syn = ev.consume & tcp_flags_i[FLAG_SYN];
		ev.ack = ev.consume & tcp_flags_i[FLAG_ACK];
		ev.fin = ev.consume & tcp_flags_i[FLAG_FIN];
		ev.rst = ev.consume & tcp_flags_i[FLAG_RST];
	end

	// Passive open request
	assign open_req = ev.syn & ~ev.ack & ~ev.rst & (state_q == ST_LISTEN);

	// Peer port remembered from the opening SYN
	always_ff @(posedge clk)
	begin
		if (open_req)
			peer_port_q <= tcp_source_port_i;
	end

	// --------------------------------------------------
	// Connection state
	// --------------------------------------------------
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			state_q <= ST_LISTEN;
		else
		begin
			case (state_q)
				ST_LISTEN:
					if (open_req)
						state_q <= ST_SYN_RCVD;
				ST_SYN_RCVD:
					if (ev.rst)
						state_q <= ST_LISTEN;
					else if (ev.syn)
						state_q <= ST_CLOSED;
					else if (ev.ack)
						state_q <= ST_ESTABLISHED;
				ST_ESTABLISHED:
					if (ev.rst & (tcp_source_port_i == peer_port_q))
						state_q <= ST_CLOSED;
					else if (ev.fin)
						state_q <= ST_CLOSE_WAIT;
				// Our FIN goes out from here
				ST_CLOSE_WAIT:
					state_q <= ST_LAST_ACK;
				ST_LAST_ACK:
					if (ev.ack)
						state_q <= ST_CLOSED;
				default:
					state_q <= ST_LISTEN;
			endcase
		end
	end

	assign tcp_op_rcv_rd_o = rd_q;
	assign seg_event_o = ev;
	assign state_o = state_q;
	assign peer_port_o = peer_port_q;

endmodule

`default_nettype wire

// ==== design/tcp_bank_arbiter.sv ====
`timescale 1ns/1ps
`default_nettype none

module tcp_bank_arbiter
#(
	parameter int N_BANKS = 8
)
(
	input wire clk,
	input wire rst_n,
	input wire [N_BANKS-1:0] req_i,
	input wire block_i,
	input wire stop_i,
	output logic [N_BANKS-1:0] sel_o,
	output logic sel_rdy_o
);
	localparam int IDX_W = (N_BANKS > 1) ? $clog2(N_BANKS) : 1;

	logic [IDX_W-1:0] ptr_q;
	logic [IDX_W-1:0] gnt_idx_q;
	logic [IDX_W-1:0] pick_idx;
	logic pick_vld;
	logic [N_BANKS-1:0] pick_oh;

	// First requester at or after the pointer, lowest distance wins
	always_comb
	begin
		pick_vld = 1'b0;
		pick_idx = '0;
		for (int k = N_BANKS - 1; k >= 0; k--)
		begin
			if (req_i[(int'(ptr_q) + k) % N_BANKS])
			begin
				pick_vld = 1'b1;
				pick_idx = IDX_W'((int'(ptr_q) + k) % N_BANKS);
			end
		end
		pick_oh = '0;
		pick_oh[pick_idx] = pick_vld;
	end

	// Grant held until the segment ends
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			sel_o <= '0;
			gnt_idx_q <= '0;
			ptr_q <= '0;
		end
		else if (|sel_o)
		begin
			if (stop_i)
			begin
				sel_o <= '0;
				ptr_q <= (gnt_idx_q == IDX_W'(N_BANKS - 1)) ? '0 : gnt_idx_q + 1'b1;
			end
		end
		else if (pick_vld & ~block_i)
		begin
			sel_o <= pick_oh;
			gnt_idx_q <= pick_idx;
		end
	end

	assign sel_rdy_o = |sel_o;

endmodule

`default_nettype wire

// ==== design/tcp_bank_slot.sv ====
`timescale 1ns/1ps
`default_nettype none

module tcp_bank_slot
(
	input wire clk,
	input wire rst_n,
	input wire wr_lock_i,
	input wire rd_lock_i,
	input wire selected_i,
	input wire wdat_start_i,
	output logic req_o
);
	logic claim_q;
	logic rd_lock_q;

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			rd_lock_q <= 1'b0;
		else
			rd_lock_q <= rd_lock_i;
	end

	// Claim keeps one fill from being sent twice
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			claim_q <= 1'b0;
		else if (~wr_lock_i | (rd_lock_i & ~rd_lock_q))
			claim_q <= 1'b0;
		else if (selected_i & wdat_start_i)
			claim_q <= 1'b1;
	end

	assign req_o = wr_lock_i & ~rd_lock_i & ~claim_q;

endmodule

`default_nettype wire

// ==== design/tcp_conn_pkg.sv ====
`default_nettype none

package tcp_conn_pkg;

	typedef enum logic [5:0] {
		ST_LISTEN = 6'b00_0001,
		ST_SYN_RCVD = 6'b00_0010,
		ST_ESTABLISHED = 6'b00_0100,
		ST_CLOSE_WAIT = 6'b00_1000,
		ST_LAST_ACK = 6'b01_0000,
		ST_CLOSED = 6'b10_0000
	} conn_state_t;

	// Decoded flags of the segment consumed this cycle
	typedef struct packed {
		logic consume;
		logic syn;
		logic ack;
		logic fin;
		logic rst;
	} seg_event_t;

	typedef enum logic [2:0] {
		RESP_NONE,
		RESP_SYNACK,
		RESP_ACK,
		RESP_FINACK,
		RESP_RST,
		RESP_RSTACK
	} resp_kind_t;

endpackage

`default_nettype wire

// ==== design/tcp_seg_pkg.sv ====
`default_nettype none

package tcp_seg_pkg;

	typedef logic [31:0] seq_t;
	typedef logic [15:0] port_t;
	typedef logic [15:0] len_t;
	typedef logic [5:0] flags_t;

	// Bit positions in the flags field
	localparam int FLAG_FIN = 0;
	localparam int FLAG_SYN = 1;
	localparam int FLAG_RST = 2;
	localparam int FLAG_PSH = 3;
	localparam int FLAG_ACK = 4;
	localparam int FLAG_URG = 5;

	// Flag sets of the segments we send
	localparam flags_t FLAGS_SYNACK = 6'h12;
	localparam flags_t FLAGS_ACK = 6'h10;
	localparam flags_t FLAGS_PSHACK = 6'h18;
	localparam flags_t FLAGS_FINACK = 6'h11;
	localparam flags_t FLAGS_RSTACK = 6'h14;
	localparam flags_t FLAGS_RST = 6'h04;

endpackage

`default_nettype wire

// ==== design/tcp_defines.svh ====
`ifndef TCP_DEFINES_SVH
`define TCP_DEFINES_SVH

// Transmit memory banks feeding the data path
`define TCP_MEM_NUM 8

// Payload bytes carried by one data segment
`define TCP_SEG_BYTES 1450

// Listening port of the server
`define TCP_LOCAL_PORT 16'hF718

// Peer window must exceed this before a new data send
`define TCP_WIN_MIN 25000

// Data sends allowed between two received ACKs
`define TCP_MAX_INFLIGHT 16

`endif
